/* test/eeprom_golden.txt */
// op (0 write, 1 read)  addr  wdata  expected rdata  expected ack_err
// block 7 (0x700 to 0x7FF) is never acknowledged
0 123 A5 00 0
1 123 00 A5 0
1 045 00 FF 0
0 2F0 3C 00 0
0 010 81 00 0
1 2F0 00 3C 0
1 010 00 81 0
0 7A0 55 00 1
1 7A0 00 00 1
0 123 5A 00 0
1 123 00 5A 0
1 6FF 00 FF 0
0 7FF 00 00 1
1 0FF 00 FF 0

/* filelist.f */
source/eeprom_pkg.sv
source/cmd_queue.sv
source/eeprom_seq.sv
source/bit_engine.sv
source/eeprom_top.sv
test/eeprom_model.sv
test/eeprom_assert.sv
test/tb_eeprom.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - files:
      - source/eeprom_pkg.sv
      - source/cmd_queue.sv
      - source/eeprom_seq.sv
      - source/bit_engine.sv
      - source/eeprom_top.sv
  - target: test
    files:
      - test/eeprom_model.sv
      - test/eeprom_assert.sv
      - test/tb_eeprom.sv

/* test/tb_eeprom.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom;
    import eeprom_pkg::*;

    localparam int MAX_CMDS   = 32;
    localparam int FIELDS     = 5;      // op addr wdata rdata err
    localparam int WAIT_LIMIT = 2000;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              full;
    logic              done;
    logic              ack_err;
    logic [DATA_W-1:0] rdata;
    logic              scl;
    wire               sda;

    logic [15:0]       golden [MAX_CMDS*FIELDS];
    int                exp_idx   [$];
    logic              exp_read  [$];
    logic [ADDR_W-1:0] exp_addr  [$];
    logic [DATA_W-1:0] exp_rdata [$];
    logic              exp_err   [$];
    int                err_count;
    int                check_count;
    int                sent_count;
    int                done_count;
    logic              saw_full;

    pullup (sda);

    eeprom_top u_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .full    (full),
        .done    (done),
        .ack_err (ack_err),
        .rdata   (rdata),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model u_model (
        .scl (scl),
        .sda (sda)
    );

    bind eeprom_top eeprom_assert u_assert (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .full  (full),
        .done  (done),
        .scl   (scl),
        .sda   (sda),
        .op    (op)
    );

    always #2 CLK = ~CLK;

    task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        check_count++;
        if (act !== exp)
        begin
            err_count++;
            $display("FAIL %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp)
        begin
            err_count++;
            $display("FAIL %s expected %0b actual %0b", name, exp, act);
        end
    endtask

    task automatic finish_cmd();
        string             name;
        logic              is_read;
        logic              e_err;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] e_rdata;
        if (exp_err.size() == 0)
        begin
            err_count++;
            $display("done pulse seen with no command outstanding");
        end
        else
        begin
            is_read = exp_read.pop_front();
            a       = exp_addr.pop_front();
            e_rdata = exp_rdata.pop_front();
            e_err   = exp_err.pop_front();
            name    = $sformatf("cmd %0d %s 0x%03h", exp_idx.pop_front(),
                                is_read ? "read" : "write", a);
            done_count++;
            check_flag({name, " ack_err"}, e_err, ack_err);
            if (is_read)
                check_byte({name, " rdata"}, e_rdata, rdata);
            else if (e_err)
                check_byte({name, " memory"}, 8'hFF, u_model.mem[a]);   // still erased
        end
    endtask

    // outputs settle between edges
    always @(negedge CLK)
    begin
        if (!RESET && full)
            saw_full = 1'b1;
        if (!RESET && full && (sent_count - done_count) < QUEUE_DEPTH)
        begin
            err_count++;
            $display("full high with only %0d commands outstanding",
                     sent_count - done_count);
        end
        if (!RESET && done)
            finish_cmd();
    end

    task automatic send_cmd(input int idx, input logic is_read, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] e_rdata,
                            input logic e_err);
        int waited;
        waited = 0;
        @(negedge CLK);
        while (full && waited < WAIT_LIMIT)
        begin
            @(negedge CLK);
            waited++;
        end
        if (full)
        begin
            err_count++;
            $display("timeout: queue stayed full before command %0d", idx);
        end
        else
        begin
            @(posedge CLK);
            wr    <= !is_read;
            rd    <= is_read;
            addr  <= a;
            wdata <= d;
            exp_idx.push_back(idx);
            exp_read.push_back(is_read);
            exp_addr.push_back(a);
            exp_rdata.push_back(e_rdata);
            exp_err.push_back(e_err);
            sent_count++;
            @(posedge CLK);
            wr <= 1'b0;
            rd <= 1'b0;
        end
    endtask

    initial
    begin
        int n;
        int base;
        int waited;
        CLK         = 1'b0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        err_count   = 0;
        check_count = 0;
        sent_count  = 0;
        done_count  = 0;
        saw_full    = 1'b0;
        void'($urandom(33));
        $readmemh("test/eeprom_golden.txt", golden);
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_flag("reset scl", 1'b1, scl);
        check_flag("reset sda", 1'b1, sda);
        check_flag("reset done", 1'b0, done);
        check_flag("reset full", 1'b0, full);

        n = 0;
        while (n < MAX_CMDS && !$isunknown(golden[n*FIELDS]) && err_count == 0)
        begin
            base = n * FIELDS;
            repeat ($urandom % 4) @(posedge CLK);   // idle gap
            send_cmd(n, golden[base][0], golden[base+1][ADDR_W-1:0],
                     golden[base+2][DATA_W-1:0], golden[base+3][DATA_W-1:0],
                     golden[base+4][0]);
            n++;
        end

        waited = 0;
        while (exp_err.size() != 0 && waited < WAIT_LIMIT)
        begin
            @(negedge CLK);
            waited++;
        end
        if (exp_err.size() != 0)
        begin
            err_count++;
            $display("timeout: %0d commands never signalled done", exp_err.size());
        end
        repeat (20) @(negedge CLK);   // catch a stray done
        if (!saw_full)
        begin
            err_count++;
            $display("full never rose while commands were waiting");
        end
        if (done_count != sent_count)
        begin
            err_count++;
            $display("%0d commands accepted but %0d done pulses", sent_count, done_count);
        end
        if (u_dut.u_assert.fail_count != 0)
        begin
            err_count += u_dut.u_assert.fail_count;
            $display("%0d assertion failures on the DUT interface",
                     u_dut.u_assert.fail_count);
        end
        $display("summary: commands %0d, checks %0d, failures %0d",
                 sent_count, check_count, err_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* test/eeprom_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_assert (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                wr,
    input  logic                rd,
    input  logic                full,
    input  logic                done,
    input  logic                scl,
    input  logic                sda,
    input  eeprom_pkg::bit_op_t op
);
    import eeprom_pkg::*;

    int fail_count = 0;   // failed assertions so far

    no_push_when_full: assert property (@(posedge CLK) disable iff (RESET)
        (wr || rd) |-> !full)
        else
        begin
            $error("command strobe given while the queue is full");
            fail_count++;
        end

    one_strobe: assert property (@(posedge CLK) disable iff (RESET)
        !(wr && rd))
        else
        begin
            $error("wr and rd given together");
            fail_count++;
        end

    done_single: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else
        begin
            $error("done held longer than one cycle");
            fail_count++;
        end

    // data may only move under a high clock for start and stop
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda != $past(sda)) |-> (op == OP_START || op == OP_STOP))
        else
        begin
            $error("sda changed while scl high outside start or stop");
            fail_count++;
        end

endmodule

`default_nettype wire

/* test/eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  wire scl,
    inout  wire sda
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_MACK
    } model_state_t;

    model_state_t      state;
    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic [DATA_W-1:0] shift;
    logic [3:0]        bit_cnt;
    logic [1:0]        byte_idx;    // 0 control, 1 address, 2 data
    logic [2:0]        block;
    logic [ADDR_W-1:0] ptr;
    logic              reading;
    logic              sda_low;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        state   = M_IDLE;
        sda_low = 1'b0;
        reading = 1'b0;
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] = 8'hFF;   // erased part
    end

    // start and stop are sda edges while scl is high
    always @(negedge sda)
    begin
        if (scl)
        begin
            state    = M_RX;
            bit_cnt  = '0;
            byte_idx = '0;
        end
    end

    always @(posedge sda)
    begin
        if (scl)
        begin
            state   = M_IDLE;
            sda_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state == M_RX)
        begin
            shift   = {shift[DATA_W-2:0], sda};
            bit_cnt = bit_cnt + 1'b1;
        end
        else if (state == M_MACK)
            state = M_IDLE;   // single byte reads only
    end

    always @(negedge scl)
    begin
        case (state)
            M_RX:
            begin
                if (bit_cnt == 4'd8)
                begin
                    bit_cnt = '0;
                    state   = M_ACK;
                    sda_low = 1'b1;
                    case (byte_idx)
                        2'd0:
                        begin
                            block   = shift[3:1];
                            reading = shift[0];
                            if (shift[7:4] != DEVICE_CODE || shift[3:1] == 3'd7)
                            begin
                                state   = M_IDLE;   // no ack for block 7
                                sda_low = 1'b0;
                            end
                        end
                        2'd1:    ptr = {block, shift};
                        default: mem[ptr] = shift;
                    endcase
                    byte_idx = byte_idx + 1'b1;
                end
            end
            M_ACK:
            begin
                sda_low = 1'b0;
                state   = M_RX;
                if (reading)
                begin
                    state   = M_TX;
                    shift   = mem[ptr];
                    sda_low = !shift[DATA_W-1];
                    shift   = shift << 1;
                    bit_cnt = 4'd1;
                end
            end
            M_TX:
            begin
                if (bit_cnt == 4'd8)
                begin
                    sda_low = 1'b0;   // let the master answer
                    state   = M_MACK;
                end
                else
                begin
                    sda_low = !shift[DATA_W-1];
                    shift   = shift << 1;
                    bit_cnt = bit_cnt + 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic                          full,
    output logic                          done,
    output logic                          ack_err,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          scl,
    inout  wire                           sda
);
    import eeprom_pkg::*;

    cmd_op_t           head_op;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_wdata;
    logic              empty;
    logic              pop;
    logic              op_start;
    bit_op_t           op;
    logic [DATA_W-1:0] tx_byte;
    logic              op_done;
    logic [DATA_W-1:0] rx_byte;
    logic              nack;

    cmd_queue u_queue (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .push_addr  (addr),
        .push_wdata (wdata),
        .pop        (pop),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .empty      (empty),
        .full       (full)
    );

    eeprom_seq u_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .empty      (empty),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .op_done    (op_done),
        .rx_byte    (rx_byte),
        .nack       (nack),
        .pop        (pop),
        .op_start   (op_start),
        .op         (op),
        .tx_byte    (tx_byte),
        .done       (done),
        .ack_err    (ack_err),
        .rdata      (rdata)
    );

    bit_engine u_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_start (op_start),
        .op       (op),
        .tx_byte  (tx_byte),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .nack     (nack),
        .scl      (scl),
        .sda      (sda)
    );

endmodule

`default_nettype wire

/* source/bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_engine (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          op_start,
    input  eeprom_pkg::bit_op_t           op,
    input  logic [eeprom_pkg::DATA_W-1:0] tx_byte,
    output logic                          op_done,
    output logic [eeprom_pkg::DATA_W-1:0] rx_byte,
    output logic                          nack,
    output logic                          scl,
    inout  wire                           sda
);
    import eeprom_pkg::*;

    bit_op_t            cur_op;
    logic               busy;
    logic [PHASE_W-1:0] phase;
    logic [3:0]         bit_cnt;     // 0..7 data, 8 ack
    logic [DATA_W-1:0]  tx_sh;
    logic               sda_low;
    logic               ack_bit;
    logic               last_bit;
    logic               ph_drive;
    logic               ph_sample;
    logic               ph_end;

    // scl low in the lower half of the period, high in the upper half
    assign ph_drive  = (phase == '0);
    assign ph_sample = (phase == {1'b1, {(PHASE_W-1){1'b0}}});
    assign ph_end    = &phase;

    assign ack_bit  = (bit_cnt == DATA_W[3:0]);
    assign last_bit = (cur_op == OP_START) || (cur_op == OP_STOP) || ack_bit;

    assign op_done = busy && ph_end && last_bit;
    assign scl     = !busy || phase[PHASE_W-1];   // parked high when idle
    assign sda     = sda_low ? 1'b0 : 1'bz;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            phase   <= '0;
            bit_cnt <= '0;
            sda_low <= 1'b0;
        end
        else if (!busy)
        begin
            if (op_start)
            begin
                busy    <= 1'b1;
                phase   <= '0;
                bit_cnt <= '0;
            end
        end
        else
        begin
            phase <= phase + 1'b1;
            if (ph_end)
            begin
                if (last_bit)
                    busy <= 1'b0;
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
            case (cur_op)
                OP_START:
                begin
                    if (ph_drive)
                        sda_low <= 1'b0;   // released first for a repeated start
                    else if (ph_sample)
                        sda_low <= 1'b1;   // falls while scl high
                end
                OP_STOP:
                begin
                    if (ph_drive)
                        sda_low <= 1'b1;
                    else if (ph_sample)
                        sda_low <= 1'b0;   // rises while scl high
                end
                OP_WRITE_BYTE:
                begin
                    if (ph_drive)
                        sda_low <= !ack_bit && !tx_sh[DATA_W-1];
                end
                default:
                begin
                    if (ph_drive)
                        sda_low <= 1'b0;   // read bits and master nack
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && op_start)
        begin
            cur_op <= op;
            tx_sh  <= tx_byte;
        end
        else if (busy)
        begin
            if (ph_drive && cur_op == OP_WRITE_BYTE && !ack_bit)
                tx_sh <= {tx_sh[DATA_W-2:0], 1'b0};   // msb first
            if (ph_sample && cur_op == OP_READ_BYTE && !ack_bit)
                rx_byte <= {rx_byte[DATA_W-2:0], sda};
            if (ph_sample && cur_op == OP_WRITE_BYTE && ack_bit)
                nack <= sda;   // high if the device let go
        end
    end

endmodule

`default_nettype wire

/* source/eeprom_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_seq (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          empty,
    input  eeprom_pkg::cmd_op_t           head_op,
    input  logic [eeprom_pkg::ADDR_W-1:0] head_addr,
    input  logic [eeprom_pkg::DATA_W-1:0] head_wdata,
    input  logic                          op_done,
    input  logic [eeprom_pkg::DATA_W-1:0] rx_byte,
    input  logic                          nack,
    output logic                          pop,
    output logic                          op_start,
    output eeprom_pkg::bit_op_t           op,
    output logic [eeprom_pkg::DATA_W-1:0] tx_byte,
    output logic                          done,
    output logic                          ack_err,
    output logic [eeprom_pkg::DATA_W-1:0] rdata
);
    import eeprom_pkg::*;

    seq_state_t        state;
    seq_state_t        next_state;
    cmd_op_t           cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              issued;      // op_start given for this state
    logic              err;         // sticky nack for the command
    bit_op_t           seq_op;
    logic [DATA_W-1:0] seq_byte;
    logic [DATA_W-1:0] ctrl_byte;

    assign pop = (state == IDLE) && !empty;

    // r/w bit set only for the second control byte of a read
    assign ctrl_byte = {DEVICE_CODE, cmd_addr[ADDR_W-1:DATA_W], state == CTRL_R};

    always_comb
    begin
        seq_op     = OP_WRITE_BYTE;
        seq_byte   = ctrl_byte;
        next_state = state;
        case (state)
            START:
            begin
                seq_op     = OP_START;
                next_state = CTRL_W;
            end
            CTRL_W:  next_state = ADDR;
            ADDR:
            begin
                seq_byte   = cmd_addr[DATA_W-1:0];
                next_state = (cmd_op == CMD_READ) ? RESTART : WDATA;
            end
            WDATA:
            begin
                seq_byte   = cmd_wdata;
                next_state = STOP;
            end
            RESTART:
            begin
                seq_op     = OP_START;
                next_state = CTRL_R;
            end
            CTRL_R:  next_state = RDATA;
            RDATA:
            begin
                seq_op     = OP_READ_BYTE;   // engine answers with master nack
                next_state = STOP;
            end
            STOP:
            begin
                seq_op     = OP_STOP;
                next_state = FINISH;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            issued   <= 1'b0;
            op_start <= 1'b0;
            done     <= 1'b0;
            ack_err  <= 1'b0;
            err      <= 1'b0;
        end
        else
        begin
            op_start <= 1'b0;
            done     <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (!empty)
                    begin
                        err   <= 1'b0;
                        state <= START;
                    end
                end
                FINISH:
                begin
                    done    <= 1'b1;
                    ack_err <= err;
                    state   <= IDLE;
                end
                default:
                begin
                    if (!issued)
                    begin
                        op_start <= 1'b1;
                        issued   <= 1'b1;
                    end
                    else if (op_done)
                    begin
                        issued <= 1'b0;
                        if (seq_op == OP_WRITE_BYTE && nack)
                        begin
                            err   <= 1'b1;
                            state <= STOP;   // skip the rest of the bytes
                        end
                        else
                            state <= next_state;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            cmd_op    <= head_op;
            cmd_addr  <= head_addr;
            cmd_wdata <= head_wdata;
        end
        if (state != IDLE && state != FINISH && !issued)
        begin
            op      <= seq_op;
            tx_byte <= seq_byte;
        end
        if (state == FINISH)
            rdata <= (cmd_op == CMD_READ && !err) ? rx_byte : '0;
    end

endmodule

`default_nettype wire

/* source/cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_queue (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] push_addr,
    input  logic [eeprom_pkg::DATA_W-1:0] push_wdata,
    input  logic                          pop,
    output eeprom_pkg::cmd_op_t           head_op,
    output logic [eeprom_pkg::ADDR_W-1:0] head_addr,
    output logic [eeprom_pkg::DATA_W-1:0] head_wdata,
    output logic                          empty,
    output logic                          full
);
    import eeprom_pkg::*;

    cmd_op_t                op_mem   [QUEUE_DEPTH];
    logic [ADDR_W-1:0]      addr_mem [QUEUE_DEPTH];
    logic [DATA_W-1:0]      data_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;
    logic                   push;
    cmd_op_t                push_op;
    logic                   pop_ok;

    assign push    = (wr || rd) && !full;   // strobe while full is lost
    assign push_op = rd ? CMD_READ : CMD_WRITE;
    assign pop_ok  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == QUEUE_DEPTH[QUEUE_PTR_W:0]);

    assign head_op    = op_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_wdata = data_mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;   // both or neither
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            op_mem[wr_ptr]   <= push_op;
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_wdata;
        end
    end

endmodule

`default_nettype wire

/* source/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W      = 11;
    localparam int DATA_W      = 8;
    localparam int QUEUE_DEPTH = 4;    // power of two so the pointers wrap
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // fixed upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int BIT_CYCLES = 4;     // two low, two high
    localparam int PHASE_W    = $clog2(BIT_CYCLES);

    typedef enum logic {
        CMD_WRITE,
        CMD_READ
    } cmd_op_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE_BYTE,
        OP_READ_BYTE
    } bit_op_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        WDATA,
        RESTART,
        CTRL_R,
        RDATA,
        STOP,
        FINISH
    } seq_state_t;

endpackage

`default_nettype wire
